/* src/fe_pkg.sv */
package fe_pkg;

  localparam int IB_DEPTH        = 16;
  localparam int FETCH_WORDS     = 4;
  localparam int MAX_OUTSTANDING = 2;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  localparam addr_t RESET_PC = 32'h0000_1000;

  // buffer index and occupancy
  typedef logic [$clog2(IB_DEPTH)-1:0] ib_ptr_t;
  typedef logic [$clog2(IB_DEPTH):0]   ib_cnt_t;   // 0..16

  typedef logic [2:0] push_cnt_t;  // 0..4
  typedef logic [1:0] pop_cnt_t;   // 0..2

  // outstanding request queue in fetch_ctrl
  typedef logic [$clog2(MAX_OUTSTANDING)-1:0] osq_ptr_t;
  typedef logic [$clog2(MAX_OUTSTANDING+1)-1:0] osq_cnt_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    word_t instr;
  } fe_instr_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;   // 16-byte aligned
  } mem_req_t;

  typedef struct packed {
    logic                         valid;
    word_t [FETCH_WORDS-1:0]      data;   // word 0 = lowest address
  } mem_rsp_t;

  typedef fe_instr_t [FETCH_WORDS-1:0] fetch_group_t;

endpackage

/* src/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             flush,
  input  fe_pkg::addr_t    redirect_pc,
  input  fe_pkg::ib_cnt_t  occupancy,
  input  fe_pkg::pop_cnt_t pop_num,
  output fe_pkg::mem_req_t mem_req,
  input  logic             mem_req_ready,
  input  logic             mem_rsp_valid,
  output logic             rsp_keep,
  output logic [1:0]       rsp_offset,
  output fe_pkg::addr_t    block_pc
);
  import fe_pkg::*;

  logic       running;
  addr_t      req_addr;
  logic [1:0] req_off;
  logic       redir_pend;
  addr_t      redir_pc;
  osq_cnt_t   inflight;
  osq_cnt_t   inflight_nxt;
  osq_cnt_t   drop_cnt;
  osq_ptr_t   wr_ptr;
  osq_ptr_t   rd_ptr;
  addr_t      q_addr [MAX_OUTSTANDING];
  logic [1:0] q_off  [MAX_OUTSTANDING];
  logic       accept;
  logic [5:0] need;

  // words the buffer must hold once every request in flight and a new one return
  assign need = 6'(occupancy) - 6'(pop_num) + {2'b00, inflight, 2'b00} + 6'd4;

  assign mem_req.valid = running && (inflight < osq_cnt_t'(MAX_OUTSTANDING)) &&
                         (need <= 6'(IB_DEPTH));
  assign mem_req.addr  = req_addr;
  assign accept        = mem_req.valid && mem_req_ready;

  assign inflight_nxt = inflight + osq_cnt_t'(accept) - osq_cnt_t'(mem_rsp_valid);

  assign rsp_keep   = mem_rsp_valid && (drop_cnt == '0);
  assign rsp_offset = q_off[rd_ptr];
  assign block_pc   = q_addr[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running    <= 1'b0;
      inflight   <= '0;
      drop_cnt   <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      redir_pend <= 1'b0;
      req_addr   <= {RESET_PC[31:4], 4'h0};
      req_off    <= RESET_PC[3:2];
    end else begin
      running  <= 1'b1;
      inflight <= inflight_nxt;
      if (accept) wr_ptr <= wr_ptr + 1'b1;
      if (mem_rsp_valid) rd_ptr <= rd_ptr + 1'b1;

      if (flush) begin
        drop_cnt <= inflight_nxt;   // everything still out is stale
      end else begin
        drop_cnt <= drop_cnt - osq_cnt_t'(mem_rsp_valid && (drop_cnt != '0))
                             + osq_cnt_t'(accept && redir_pend);
      end

      if (flush && mem_req.valid && !mem_req_ready) begin
        redir_pend <= 1'b1;   // old request still on the bus, keep it stable
      end else if (flush) begin
        redir_pend <= 1'b0;
        req_addr   <= {redirect_pc[31:4], 4'h0};
        req_off    <= redirect_pc[3:2];
      end else if (accept && redir_pend) begin
        redir_pend <= 1'b0;
        req_addr   <= {redir_pc[31:4], 4'h0};
        req_off    <= redir_pc[3:2];
      end else if (accept) begin
        req_addr <= req_addr + 32'd16;
        req_off  <= 2'd0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (flush) redir_pc <= redirect_pc;
    if (accept) begin
      q_addr[wr_ptr] <= req_addr;
      q_off[wr_ptr]  <= req_off;
    end
  end

endmodule

/* src/fetch_align.sv */
`timescale 1ns/1ps

module fetch_align (
  input  fe_pkg::mem_rsp_t     mem_rsp,
  input  logic                 rsp_keep,
  input  logic [1:0]           rsp_offset,
  input  fe_pkg::addr_t        block_pc,
  output fe_pkg::fetch_group_t push_group,
  output fe_pkg::push_cnt_t    push_num
);
  import fe_pkg::*;

  logic keep;

  assign keep = rsp_keep && mem_rsp.valid;

  // shift down so the start pc lands in entry 0
  always_comb begin
    logic [2:0] src;
    push_group = '0;
    for (int i = 0; i < FETCH_WORDS; i++) begin
      src = 3'(i) + 3'(rsp_offset);
      if (src < 3'(FETCH_WORDS)) begin
        push_group[i].valid = keep;
        push_group[i].pc    = block_pc + addr_t'({src, 2'b00});
        push_group[i].instr = mem_rsp.data[src[1:0]];
      end
    end
  end

  assign push_num = keep ? push_cnt_t'(FETCH_WORDS) - push_cnt_t'(rsp_offset) : '0;

endmodule

/* src/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 flush,
  input  fe_pkg::fetch_group_t push_group,
  input  fe_pkg::push_cnt_t    push_num,
  input  fe_pkg::pop_cnt_t     pop_num,
  output fe_pkg::ib_cnt_t      occupancy,
  output fe_pkg::fe_instr_t    head0,
  output fe_pkg::fe_instr_t    head1
);
  import fe_pkg::*;

  fe_instr_t mem [IB_DEPTH];
  ib_ptr_t   head_ptr;
  ib_ptr_t   tail_ptr;
  ib_cnt_t   count;

  // pointers wrap mod 16 on their own
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else if (flush) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      tail_ptr <= tail_ptr + ib_ptr_t'(push_num);
      head_ptr <= head_ptr + ib_ptr_t'(pop_num);
      count    <= count + ib_cnt_t'(push_num) - ib_cnt_t'(pop_num);
    end
  end

  always_ff @(posedge clk) begin
    if (!flush) begin
      for (int i = 0; i < FETCH_WORDS; i++) begin
        if (3'(i) < push_num) begin
          mem[tail_ptr + ib_ptr_t'(i)] <= push_group[i];
        end
      end
    end
  end

  assign occupancy = count;

  // valids come from the count, never from stored entries
  always_comb begin
    head0       = mem[head_ptr];
    head0.valid = (count >= ib_cnt_t'(1));
    head1       = mem[head_ptr + ib_ptr_t'(1)];
    head1.valid = (count >= ib_cnt_t'(2));
  end

endmodule

/* src/issue_select.sv */
`timescale 1ns/1ps

module issue_select (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              flush,
  input  fe_pkg::fe_instr_t head0,
  input  fe_pkg::fe_instr_t head1,
  input  logic              dec_ready,
  output fe_pkg::pop_cnt_t  pop_num,
  output fe_pkg::fe_instr_t dec_slot0,
  output fe_pkg::fe_instr_t dec_slot1
);
  import fe_pkg::*;

  logic  load;
  logic  v0;
  logic  v1;
  addr_t pc0;
  addr_t pc1;
  word_t ins0;
  word_t ins1;

  assign load = !v0 || dec_ready;   // slots empty or taken now

  always_comb begin
    if (!load) begin
      pop_num = 2'd0;
    end else if (head1.valid) begin
      pop_num = 2'd2;
    end else if (head0.valid) begin
      pop_num = 2'd1;
    end else begin
      pop_num = 2'd0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v0 <= 1'b0;
      v1 <= 1'b0;
    end else if (flush) begin
      v0 <= 1'b0;
      v1 <= 1'b0;
    end else if (load) begin
      v0 <= head0.valid;
      v1 <= head1.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      pc0  <= head0.pc;
      ins0 <= head0.instr;
      pc1  <= head1.pc;
      ins1 <= head1.instr;
    end
  end

  assign dec_slot0 = '{valid: v0, pc: pc0, instr: ins0};
  assign dec_slot1 = '{valid: v1, pc: pc1, instr: ins1};

endmodule

/* src/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              flush,
  input  fe_pkg::addr_t     redirect_pc,
  output fe_pkg::mem_req_t  mem_req,
  input  logic              mem_req_ready,
  input  fe_pkg::mem_rsp_t  mem_rsp,
  output fe_pkg::fe_instr_t dec_slot0,
  output fe_pkg::fe_instr_t dec_slot1,
  input  logic              dec_ready
);
  import fe_pkg::*;

  ib_cnt_t      occupancy;
  pop_cnt_t     pop_num;
  logic         rsp_keep;
  logic [1:0]   rsp_offset;
  addr_t        block_pc;
  fetch_group_t push_group;
  push_cnt_t    push_num;
  fe_instr_t    head0;
  fe_instr_t    head1;

  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .arst_n        (arst_n),
    .flush         (flush),
    .redirect_pc   (redirect_pc),
    .occupancy     (occupancy),
    .pop_num       (pop_num),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp.valid),
    .rsp_keep      (rsp_keep),
    .rsp_offset    (rsp_offset),
    .block_pc      (block_pc)
  );

  fetch_align u_fetch_align (
    .mem_rsp    (mem_rsp),
    .rsp_keep   (rsp_keep),
    .rsp_offset (rsp_offset),
    .block_pc   (block_pc),
    .push_group (push_group),
    .push_num   (push_num)
  );

  instr_buffer u_instr_buffer (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .push_group (push_group),
    .push_num   (push_num),
    .pop_num    (pop_num),
    .occupancy  (occupancy),
    .head0      (head0),
    .head1      (head1)
  );

  issue_select u_issue_select (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .head0     (head0),
    .head1     (head1),
    .dec_ready (dec_ready),
    .pop_num   (pop_num),
    .dec_slot0 (dec_slot0),
    .dec_slot1 (dec_slot1)
  );

endmodule

/* dv/frontend_assert.sv */
`timescale 1ns/1ps

module frontend_assert (
  input logic              clk,
  input logic              arst_n,
  input logic              flush,
  input fe_pkg::mem_req_t  mem_req,
  input logic              mem_req_ready,
  input fe_pkg::ib_cnt_t   occupancy,
  input fe_pkg::fe_instr_t dec_slot0,
  input fe_pkg::fe_instr_t dec_slot1,
  input logic              dec_ready
);
  import fe_pkg::*;

  int fail_cnt = 0;   // read by the testbench at the end

  occ_max: assert property (@(posedge clk) disable iff (!arst_n)
    occupancy <= ib_cnt_t'(IB_DEPTH))
    else begin
      fail_cnt++;
      $error("buffer occupancy %0d above depth", occupancy);
    end

  // request held on the bus until accepted
  req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    mem_req.valid && !mem_req_ready |=> $stable(mem_req.addr))
    else begin
      fail_cnt++;
      $error("request address changed before acceptance");
    end

  slot_order: assert property (@(posedge clk) disable iff (!arst_n)
    dec_slot1.valid |-> dec_slot0.valid)
    else begin
      fail_cnt++;
      $error("decode slot 1 valid without slot 0");
    end

  slot_hold: assert property (@(posedge clk) disable iff (!arst_n)
    dec_slot0.valid && !dec_ready && !flush |=> $stable(dec_slot0) && $stable(dec_slot1))
    else begin
      fail_cnt++;
      $error("decode slots changed under back-pressure");
    end

endmodule

bind frontend_top frontend_assert u_frontend_assert (
  .clk           (clk),
  .arst_n        (arst_n),
  .flush         (flush),
  .mem_req       (mem_req),
  .mem_req_ready (mem_req_ready),
  .occupancy     (occupancy),
  .dec_slot0     (dec_slot0),
  .dec_slot1     (dec_slot1),
  .dec_ready     (dec_ready)
);

/* dv/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb;
  import fe_pkg::*;

  localparam int RESET_CYCLES    = 16;
  localparam int SEQ_CYCLES      = 300;
  localparam int HOLD_CYCLES     = 40;
  localparam int RUN_CYCLES      = 200;
  localparam int TOTAL_CYCLES    = RESET_CYCLES + SEQ_CYCLES + 5 * RUN_CYCLES +
                                   2 * HOLD_CYCLES + 8;
  localparam int WATCHDOG_CYCLES = 2 * TOTAL_CYCLES;   // room for memory stalls

  logic      clk;
  logic      arst_n;
  logic      flush;
  addr_t     redirect_pc;
  mem_req_t  mem_req;
  logic      mem_req_ready;
  mem_rsp_t  mem_rsp;
  fe_instr_t dec_slot0;
  fe_instr_t dec_slot1;
  logic      dec_ready;

  int    seed           = 12;
  int    cycle          = 0;
  int    mismatches     = 0;
  int    other_errors   = 0;
  int    taken          = 0;
  int    taken_at_start = 0;
  logic  hold_ready     = 1'b0;
  string test_name      = "reset_seq";
  addr_t exp_pc         = RESET_PC;
  addr_t req_q [$];   // accepted block addresses, oldest first
  int    due_q [$];

  frontend_top dut (
    .clk           (clk),
    .arst_n        (arst_n),
    .flush         (flush),
    .redirect_pc   (redirect_pc),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp       (mem_rsp),
    .dec_slot0     (dec_slot0),
    .dec_slot1     (dec_slot1),
    .dec_ready     (dec_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // memory and decode sink, driven just after the edge
  always @(posedge clk) begin
    logic  hold_now;
    addr_t base;
    hold_now = hold_ready;
    cycle    = cycle + 1;
    #2;
    mem_req_ready = ($unsigned($random(seed)) % 4) != 0;
    dec_ready     = !hold_now && (($unsigned($random(seed)) % 10) < 6);
    mem_rsp       = '0;
    if (req_q.size() > 0 && due_q[0] <= cycle) begin
      base          = req_q.pop_front();
      due_q.delete(0);
      mem_rsp.valid = 1'b1;
      for (int i = 0; i < FETCH_WORDS; i++) begin
        mem_rsp.data[i] = (base + addr_t'(4 * i)) ^ 32'hA5A5_0000;
      end
    end
  end

  task automatic check_instr(input fe_instr_t slot);
    assert (slot.pc == exp_pc) else begin
      mismatches++;
      $display("mismatch %s pc expected %h actual %h", test_name, exp_pc, slot.pc);
    end
    assert (slot.instr == (exp_pc ^ 32'hA5A5_0000)) else begin
      mismatches++;
      $display("mismatch %s instr expected %h actual %h", test_name,
               exp_pc ^ 32'hA5A5_0000, slot.instr);
    end
    exp_pc = slot.pc + 32'd4;   // resync, one slip gives one error
    taken++;
  endtask

  // sampled mid-cycle where all inputs and outputs are settled
  always @(negedge clk) begin
    if (arst_n) begin
      if (mem_req.valid && mem_req_ready) begin
        req_q.push_back(mem_req.addr);
        due_q.push_back(cycle + 1 + int'($unsigned($random(seed)) % 4));
      end
      if (dec_slot0.valid && dec_ready) begin
        check_instr(dec_slot0);
        if (dec_slot1.valid) check_instr(dec_slot1);
      end
      if (flush) exp_pc = redirect_pc;   // pair taken on the flush edge is still old
    end
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    taken_at_start = taken;
  endtask

  task automatic check_progress();
    assert (taken > taken_at_start) else begin
      other_errors++;
      $display("no instruction reached decode during %s", test_name);
    end
  endtask

  task automatic apply_flush(input addr_t target, input bit keep_high);
    flush       = 1'b1;
    redirect_pc = target;
    @(posedge clk);
    #2;
    if (!keep_high) begin
      flush          = 1'b0;
      taken_at_start = taken;
    end
  endtask

  task automatic wait_inflight();
    int pending;
    pending = 0;
    while (pending == 0) begin
      @(posedge clk);
      #1;   // queues settled, this cycle's response not yet popped
      pending = req_q.size();
      if (pending > 0 && due_q[0] <= cycle) pending--;   // answered this cycle
    end
    #1;
  endtask

  task automatic finish_run();
    int assert_fails;
    assert_fails = dut.u_frontend_assert.fail_cnt;
    $display("taken %0d, mismatches %0d, other errors %0d, assertion failures %0d",
             taken, mismatches, other_errors, assert_fails);
    if (mismatches + other_errors + assert_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  initial begin
    arst_n        = 1'b0;
    flush         = 1'b0;
    redirect_pc   = '0;
    mem_req_ready = 1'b0;
    mem_rsp       = '0;
    dec_ready     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;

    start_test("reset_seq");
    wait_cycles(RUN_CYCLES);
    check_progress();

    start_test("stream");
    wait_cycles(SEQ_CYCLES);
    check_progress();

    start_test("backpressure");
    hold_ready = 1'b1;
    wait_cycles(HOLD_CYCLES);
    assert (dut.occupancy >= ib_cnt_t'(13)) else begin
      other_errors++;
      $display("buffer did not fill under back-pressure, occupancy %0d", dut.occupancy);
    end
    hold_ready = 1'b0;
    wait_cycles(RUN_CYCLES);
    check_progress();

    start_test("redirect_unaligned");
    wait_inflight();   // stale responses still out
    apply_flush(32'h0000_2008, 1'b0);
    wait_cycles(RUN_CYCLES);
    check_progress();

    start_test("flush_back_to_back");
    wait_inflight();
    apply_flush(32'h0000_3000, 1'b1);
    apply_flush(32'h0000_3014, 1'b0);
    wait_cycles(RUN_CYCLES);
    check_progress();

    start_test("flush_full");
    hold_ready = 1'b1;
    wait_cycles(HOLD_CYCLES);
    hold_ready = 1'b0;
    apply_flush(32'h0000_500c, 1'b0);
    wait_cycles(RUN_CYCLES);
    check_progress();

    finish_run();
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    other_errors++;
    $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    finish_run();
  end

endmodule

/* list.f */
src/fe_pkg.sv
src/fetch_ctrl.sv
src/fetch_align.sv
src/instr_buffer.sv
src/issue_select.sv
src/frontend_top.sv
dv/frontend_assert.sv
dv/frontend_tb.sv

/* Makefile */
TOP := frontend_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed" $(LOG) || (echo "FAIL: no result in $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
